// File: data_bus_cfg.svh
/*
 * data bus memory map: region count, bases, sizes and the shared word index width
 */
`ifndef DATA_BUS_CFG_SVH
`define DATA_BUS_CFG_SVH

// regions on the data bus
// index 0 is main memory, 1 is the palette, 2 is the framebuffer
`define NUM_REGIONS 3

// each base must be a multiple of its size,
// so the upper address bits alone pick the region
`define MEM_BASE 32'h0000_0000
`define MEM_BYTES 1024

// 384-byte palette rounded up to a power of two
`define PAL_BASE 32'h0000_0800
`define PAL_BYTES 512

// scaled down for simulation
`define FB_BASE 32'h0002_0000
`define FB_BYTES 16384

// bytes per bus word, address bits [1:0] are dropped
`define WORD_BYTES 4

// word index of the largest region, FB_BYTES / WORD_BYTES = 4096 words
`define REGION_ADDR_W 12

`endif

// File: data_bus_pkg.sv
/*
 * data bus types: the request issued by the CPU and the request seen by one region
 */
`default_nettype none

`include "data_bus_cfg.svh"

package data_bus_pkg;

    // request as driven by the CPU data side
    // there is no strobe, the address is always a read
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wr_data;
        logic        wr_en;
    } bus_req_t;

    // request after decode, one per region
    // word_addr is zero-extended for the smaller regions
    typedef struct packed {
        logic [`REGION_ADDR_W-1:0] word_addr;
        logic [31:0]               wr_data;
        logic                      wr_en;
    } region_req_t;

endpackage

`default_nettype wire

// File: data_bus.sv
/*
 * data bus decoder: matches the upper address bits against each region base,
 * slices the word index and gates the write enable per region
 */
`timescale 1ns/1ns
`default_nettype none

`include "data_bus_cfg.svh"

module data_bus
    import data_bus_pkg::*;
(
    input  bus_req_t                 bus,
    output region_req_t              region_req [`NUM_REGIONS],
    output logic [`NUM_REGIONS-1:0]  hit
);

    // base and size of each region, same order as the region index
    localparam logic [31:0] REGION_BASE [`NUM_REGIONS] = '{
        `MEM_BASE,
        `PAL_BASE,
        `FB_BASE
    };

    localparam int unsigned REGION_BYTES [`NUM_REGIONS] = '{
        `MEM_BYTES,
        `PAL_BYTES,
        `FB_BYTES
    };

    localparam int unsigned ADDR_W = `REGION_ADDR_W;

    for (genvar i = 0; i < `NUM_REGIONS; i++) begin : g_region
        // lowest address bit that selects the region
        localparam int unsigned SEL_LSB = $clog2(REGION_BYTES[i]);

        // region hit when the bits above the region size match its base
        assign hit[i] = (bus.addr[31:SEL_LSB] == REGION_BASE[i][31:SEL_LSB]);

        // word index within the region, byte offset dropped
        assign region_req[i].word_addr = ADDR_W'(bus.addr[SEL_LSB-1:2]);
        assign region_req[i].wr_data   = bus.wr_data;
        assign region_req[i].wr_en     = bus.wr_en && hit[i];

        // a misaligned base would make the upper-bit compare
        // claim addresses outside the region
        region_base_aligned: assert property (
            @(posedge bus.wr_en)
            (REGION_BASE[i] & (REGION_BYTES[i] - 1)) == 0
        ) else $error("region %0d base %h not aligned to its size %0d",
                      i, REGION_BASE[i], REGION_BYTES[i]);
    end

    // overlapping regions would show up as two hits at once,
    // and the read mux would then hide the higher region
    hit_onehot: assert property (
        @(posedge bus.wr_en)
        $onehot0(hit)
    ) else $error("address %h hits several regions, hit = %b", bus.addr, hit);

endmodule

`default_nettype wire

// File: region_ram.sv
/*
 * region RAM: single-port word array behind one decoded region,
 * synchronous write and registered read-before-write output
 */
`timescale 1ns/1ns
`default_nettype none

`include "data_bus_cfg.svh"

module region_ram
    import data_bus_pkg::*;
#(
    parameter int unsigned DEPTH_WORDS = 256
) (
    input  logic        clk,
    input  region_req_t req,
    output logic [31:0] rdata
);

    localparam int unsigned IDX_W = $clog2(DEPTH_WORDS);

    logic [31:0]      mem [DEPTH_WORDS];
    logic [IDX_W-1:0] idx;

    // the shared word index is wide enough for the biggest region,
    // smaller regions only look at their own bits
    assign idx = req.word_addr[IDX_W-1:0];

    // read returns the old word when the same word is written
    always_ff @(posedge clk) begin
        if (req.wr_en) begin
            mem[idx] <= req.wr_data;
        end
        rdata <= mem[idx];
    end

    // the decoder only enables a write inside the region,
    // so the upper index bits must already be zero
    write_in_range: assert property (
        @(posedge clk)
        req.wr_en |-> (req.word_addr < DEPTH_WORDS)
    ) else $error("write to word %0d beyond depth %0d",
                  req.word_addr, DEPTH_WORDS);

endmodule

`default_nettype wire

// File: read_data_mux.sv
/*
 * read data mux: registers the region hit vector so it lines up with
 * the registered RAM outputs, then returns the word of the hit region
 */
`timescale 1ns/1ns
`default_nettype none

`include "data_bus_cfg.svh"

module read_data_mux (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`NUM_REGIONS-1:0] hit,
    input  logic [31:0]             rdata [`NUM_REGIONS],
    output logic [31:0]             rd_data
);

    logic [`NUM_REGIONS-1:0] hit_q;

    // same edge as the RAM read, so select and data belong to one address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hit_q <= '0;
        end else begin
            hit_q <= hit;
        end
    end

    // lowest index wins, unmapped reads return zero
    // scan from the top so the lowest hit is assigned last
    always_comb begin
        rd_data = '0;
        for (int i = `NUM_REGIONS - 1; i >= 0; i--) begin
            if (hit_q[i]) begin
                rd_data = rdata[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: data_bus_top.sv
/*
 * data bus top: decoder, one RAM per memory-mapped region and the read data mux
 */
`timescale 1ns/1ns
`default_nettype none

`include "data_bus_cfg.svh"

module data_bus_top
    import data_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  bus_req_t    bus,
    output logic [31:0] rd_data
);

    // region sizes in bytes, same order as the decoder
    localparam int unsigned REGION_BYTES [`NUM_REGIONS] = '{
        `MEM_BYTES,
        `PAL_BYTES,
        `FB_BYTES
    };

    region_req_t             region_req [`NUM_REGIONS];
    logic [`NUM_REGIONS-1:0] hit;
    logic [31:0]             rdata [`NUM_REGIONS];

    data_bus i_data_bus (
        .bus        (bus),
        .region_req (region_req),
        .hit        (hit)
    );

    // memory, palette and framebuffer
    for (genvar i = 0; i < `NUM_REGIONS; i++) begin : g_ram
        region_ram #(
            .DEPTH_WORDS (REGION_BYTES[i] / `WORD_BYTES)
        ) i_region_ram (
            .clk   (clk),
            .req   (region_req[i]),
            .rdata (rdata[i])
        );
    end

    read_data_mux i_read_data_mux (
        .clk     (clk),
        .rst_n   (rst_n),
        .hit     (hit),
        .rdata   (rdata),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// File: bus_checker.sv
/*
 * bus checker: reference model of the three regions, compares rd_data
 * one cycle after each address and counts checks and errors
 */
`timescale 1ns/1ns
`default_nettype none

`include "data_bus_cfg.svh"

module bus_checker
    import data_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  bus_req_t    bus,
    input  logic [31:0] rd_data,
    output int          error_count,
    output int          check_count
);

    localparam logic [31:0] REGION_BASE [`NUM_REGIONS] = '{`MEM_BASE, `PAL_BASE, `FB_BASE};
    localparam int unsigned REGION_BYTES [`NUM_REGIONS] = '{`MEM_BYTES, `PAL_BYTES, `FB_BYTES};
    localparam int unsigned REGION_WORDS_MAX = 1 << `REGION_ADDR_W;

    // model words keyed by region and word index, absent until written
    logic [31:0] model [int unsigned];

    int          errors = 0;
    int          checks = 0;
    int          region;
    int unsigned key;
    logic        pend_check = 1'b0;
    logic [31:0] pend_exp;
    logic [31:0] pend_addr;

    assign error_count = errors;
    assign check_count = checks;

    // region whose base matches the bits above its size, -1 if unmapped
    function automatic int region_of(input logic [31:0] addr);
        for (int i = 0; i < `NUM_REGIONS; i++) begin
            if ((addr & ~(REGION_BYTES[i] - 1)) == REGION_BASE[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // expected read word is taken before this cycle's write lands
    always @(posedge clk) begin
        pend_addr = bus.addr;
        if (!rst_n) begin
            // mux hit register is cleared, so the output reads zero
            pend_check = 1'b1;
            pend_exp   = '0;
        end else begin
            region = region_of(bus.addr);
            if (region < 0) begin
                pend_check = 1'b1;
                pend_exp   = '0;
            end else begin
                key = region * REGION_WORDS_MAX
                    + ((bus.addr & (REGION_BYTES[region] - 1)) >> 2);
                pend_check = model.exists(key);
                pend_exp   = pend_check ? model[key] : '0;
                if (bus.wr_en) begin
                    model[key] = bus.wr_data;
                end
            end
        end
    end

    // rd_data has settled by the falling edge
    always @(negedge clk) begin
        if (pend_check) begin
            checks = checks + 1;
            if (rd_data !== pend_exp) begin
                errors = errors + 1;
                $display("** Error: rd_data = %h, expected %h, addr %h at %0t ns",
                         rd_data, pend_exp, pend_addr, $time);
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_data_bus.sv
/*
 * data bus testbench with seeded random fill and access phases against the
 * region model in bus_checker, a watchdog and one closing report
 */
`timescale 1ns/1ns
`default_nettype none

`include "data_bus_cfg.svh"

module tb_data_bus
    import data_bus_pkg::*;
();

    localparam int unsigned CLK_HALF_NS   = 20;
    localparam int unsigned RESET_CYCLES  = 4;
    localparam int unsigned RANDOM_CYCLES = 3000;
    localparam int unsigned FILL_WORDS =
        (`MEM_BYTES + `PAL_BYTES + `FB_BYTES) / `WORD_BYTES;
    localparam int unsigned TIMEOUT_NS =
        (FILL_WORDS + RANDOM_CYCLES + 100) * 2 * CLK_HALF_NS;
    localparam logic [31:0] SEED = 32'h37df_7508;

    localparam logic [31:0] REGION_BASE [`NUM_REGIONS] = '{`MEM_BASE, `PAL_BASE, `FB_BASE};
    localparam int unsigned REGION_BYTES [`NUM_REGIONS] = '{`MEM_BYTES, `PAL_BYTES, `FB_BYTES};

    logic        clk;
    logic        rst_n;
    bus_req_t    bus;
    logic [31:0] rd_data;
    logic [31:0] last_addr;
    int          error_count;
    int          check_count;

    always #CLK_HALF_NS clk = ~clk;

    data_bus_top i_data_bus_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus     (bus),
        .rd_data (rd_data)
    );

    bus_checker i_bus_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (bus),
        .rd_data     (rd_data),
        .error_count (error_count),
        .check_count (check_count)
    );

    task automatic drive_access(input logic [31:0] addr, input logic [31:0] data,
                                input logic wr_en);
        @(negedge clk);
        bus.addr    = addr;
        bus.wr_data = data;
        bus.wr_en   = wr_en;
    endtask

    // every word of every region once in shuffled order
    task automatic fill_regions();
        logic [31:0] addrs [$];
        logic [31:0] tmp;
        int          j;
        for (int r = 0; r < `NUM_REGIONS; r++) begin
            for (int unsigned off = 0; off < REGION_BYTES[r]; off += `WORD_BYTES) begin
                addrs.push_back(REGION_BASE[r] + off);
            end
        end
        for (int i = addrs.size() - 1; i > 0; i--) begin
            j        = int'($urandom % (i + 1));
            tmp      = addrs[i];
            addrs[i] = addrs[j];
            addrs[j] = tmp;
        end
        foreach (addrs[i]) begin
            drive_access(addrs[i], $urandom, 1'b1);
        end
    endtask

    // mostly mapped addresses with some unmapped ones and repeats of the last address
    function automatic logic [31:0] pick_address();
        int unsigned sel;
        sel = $urandom % 16;
        if (sel < 4) return `MEM_BASE + ($urandom % `MEM_BYTES);
        if (sel < 8) return `PAL_BASE + ($urandom % `PAL_BYTES);
        if (sel < 13) return `FB_BASE + ($urandom % `FB_BYTES);
        if (sel == 13) return $urandom;
        // gap between memory and palette
        if (sel == 14) return 32'h0000_0400 + ($urandom % 1024);
        return last_addr;
    endfunction

    task automatic random_accesses();
        logic [31:0] addr;
        int unsigned coin;
        repeat (RANDOM_CYCLES) begin
            addr      = pick_address();
            coin      = $urandom % 2;
            last_addr = addr;
            drive_access(addr, $urandom, coin[0]);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        clk       = 1'b0;
        rst_n     = 1'b0;
        bus       = '0;
        last_addr = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        fill_regions();
        random_accesses();
        // idle on an unmapped address so the last read gets compared
        drive_access(32'h0000_0400, '0, 1'b0);
        repeat (2) @(posedge clk);
        $display("errors: %0d, checks: %0d", error_count, check_count);
        if (error_count == 0 && check_count > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: bus accesses still running after %0d ns", TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
data_bus_pkg.sv
data_bus.sv
region_ram.sv
read_data_mux.sv
data_bus_top.sv
bus_checker.sv
tb_data_bus.sv

// File: Makefile
# Verilator flow for the data bus testbench

VERILATOR ?= verilator
TOP       ?= tb_data_bus
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
SIM_ARGS  ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only if the pass line shows up in the simulator output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
